//--- beam_mac.sv
`default_nettype none

module beam_mac
    import bf_dims_pkg::*;
    import bf_types_pkg::*;
(
    input  wire logic     i_clk,
    input  wire logic     i_reset,
    input  wire ant_vec_t i_re,
    input  wire logic     i_re_vld,
    input  wire cw_wr_t   i_cw_wr,
    input  wire logic     i_cw_wr_en,
    output beam_vec_t     o_beam,
    output logic          o_beam_vld
);

    // codeword matrix, row per beam
    cplx_t [BEAM_NUM-1:0][ANT_NUM-1:0] cw;

    // partial products of w * x
    logic signed [2*IQ_W-1:0] prod_ii [BEAM_NUM][ANT_NUM];
    logic signed [2*IQ_W-1:0] prod_qq [BEAM_NUM][ANT_NUM];
    logic signed [2*IQ_W-1:0] prod_iq [BEAM_NUM][ANT_NUM];
    logic signed [2*IQ_W-1:0] prod_qi [BEAM_NUM][ANT_NUM];
    logic                     vld_s1;

    beam_vec_t beam_sum;

    // --------------------------------------------------
    // codeword storage
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cw <= '0;
        end else if (i_cw_wr_en) begin
            cw[i_cw_wr.beam][i_cw_wr.ant] <= i_cw_wr.w;
        end
    end

    // --------------------------------------------------
    // stage 1: complex products
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < BEAM_NUM; b++) begin
            for (int a = 0; a < ANT_NUM; a++) begin
                prod_ii[b][a] <= $signed(cw[b][a].i) * $signed(i_re[a].i);
                prod_qq[b][a] <= $signed(cw[b][a].q) * $signed(i_re[a].q);
                prod_iq[b][a] <= $signed(cw[b][a].i) * $signed(i_re[a].q);
                prod_qi[b][a] <= $signed(cw[b][a].q) * $signed(i_re[a].i);
            end
        end
    end

    // --------------------------------------------------
    // stage 2: sum over antennas
    // --------------------------------------------------
    always_comb begin : antenna_sum
        logic signed [BEAM_W-1:0] acc_re;
        logic signed [BEAM_W-1:0] acc_im;
        for (int b = 0; b < BEAM_NUM; b++) begin
            acc_re = '0;
            acc_im = '0;
            // products sign-extend into the wider sum
            for (int a = 0; a < ANT_NUM; a++) begin
                acc_re = acc_re + prod_ii[b][a] - prod_qq[b][a];
                acc_im = acc_im + prod_iq[b][a] + prod_qi[b][a];
            end
            beam_sum[b].i = acc_re;
            beam_sum[b].q = acc_im;
        end
    end

    always_ff @(posedge i_clk) begin
        o_beam <= beam_sum;
    end

    // valid follows the two data stages
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            vld_s1     <= 1'b0;
            o_beam_vld <= 1'b0;
        end else begin
            vld_s1     <= i_re_vld;
            o_beam_vld <= vld_s1;
        end
    end

endmodule

`default_nettype wire

//--- bf_dims_pkg.sv
`default_nettype none

package bf_dims_pkg;

    // --------------------------------------------------
    // array size
    // --------------------------------------------------
    localparam int ANT_NUM    = 4;
    localparam int BEAM_NUM   = 4;
    localparam int ANT_IDX_W  = $clog2(ANT_NUM);
    localparam int BEAM_IDX_W = $clog2(BEAM_NUM);

    // --------------------------------------------------
    // datapath widths
    // --------------------------------------------------
    // one I or Q of a sample or a weight
    localparam int IQ_W      = 16;
    // beam component and rbg accumulator
    localparam int BEAM_W    = 40;
    localparam int PWR_SHIFT = 8;

    // --------------------------------------------------
    // rbg counting
    // --------------------------------------------------
    localparam int RBG_IDX_W     = 6;
    localparam int RE_CNT_W      = 8;
    localparam int RE_PER_RBG_S0 = 48;
    localparam int RE_PER_RBG_S1 = 96;
    localparam int RE_PER_RBG_S2 = 192;

    // pipeline depths
    localparam int MAC_LAT = 2;
    localparam int PWR_LAT = 3;

endpackage

`default_nettype wire

//--- bf_types_pkg.sv
`default_nettype none

package bf_types_pkg;

    import bf_dims_pkg::*;

    // --------------------------------------------------
    // antenna side
    // --------------------------------------------------
    typedef struct packed {
        logic signed [IQ_W-1:0] i;
        logic signed [IQ_W-1:0] q;
    } cplx_t;

    // one re over all antennas
    typedef cplx_t [ANT_NUM-1:0] ant_vec_t;

    // single codeword entry write
    typedef struct packed {
        logic [BEAM_IDX_W-1:0] beam;
        logic [ANT_IDX_W-1:0]  ant;
        cplx_t                 w;
    } cw_wr_t;

    // --------------------------------------------------
    // beam side
    // --------------------------------------------------
    typedef struct packed {
        logic signed [BEAM_W-1:0] i;
        logic signed [BEAM_W-1:0] q;
    } beam_cplx_t;

    typedef beam_cplx_t [BEAM_NUM-1:0] beam_vec_t;

    // per-re position inside the rbg, flags only meaningful with valid
    typedef struct packed {
        logic                 valid;
        logic                 rbg_first;
        logic                 rbg_last;
        logic                 sym_end;
        logic [RBG_IDX_W-1:0] rbg_idx;
    } rbg_tag_t;

    // unsigned power per beam
    typedef logic [BEAM_W-1:0]      pwr_t;
    typedef pwr_t [BEAM_NUM-1:0]    pwr_vec_t;

    typedef struct packed {
        logic [RBG_IDX_W-1:0] rbg_idx;
        logic                 sym_end;
        pwr_vec_t             pwr;
    } rbg_power_t;

endpackage

`default_nettype wire

//--- pdsch_beam_power.sv
`default_nettype none

module pdsch_beam_power
    import bf_types_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset,
    input  wire ant_vec_t   i_re,
    input  wire logic       i_re_vld,
    input  wire logic       i_re_sop,
    input  wire logic       i_re_eop,
    input  wire logic [1:0] i_rbg_size,
    input  wire cw_wr_t     i_cw_wr,
    input  wire logic       i_cw_wr_en,
    output rbg_power_t      o_pwr,
    output logic            o_pwr_vld
);

    beam_vec_t beam;
    logic      beam_vld;
    rbg_tag_t  beam_tag;

    // --------------------------------------------------
    // beams and rbg tags run side by side
    // --------------------------------------------------
    beam_mac beam_mac_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_re       (i_re),
        .i_re_vld   (i_re_vld),
        .i_cw_wr    (i_cw_wr),
        .i_cw_wr_en (i_cw_wr_en),
        .o_beam     (beam),
        .o_beam_vld (beam_vld)
    );

    rbg_tracker rbg_tracker_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_re_vld   (i_re_vld),
        .i_re_sop   (i_re_sop),
        .i_re_eop   (i_re_eop),
        .i_rbg_size (i_rbg_size),
        .o_tag      (beam_tag)
    );

    // power result 3 cycles after the beam
    rbg_power_acc rbg_power_acc_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_beam     (beam),
        .i_beam_vld (beam_vld),
        .i_tag      (beam_tag),
        .o_pwr      (o_pwr),
        .o_pwr_vld  (o_pwr_vld)
    );

endmodule

`default_nettype wire

//--- rbg_power_acc.sv
`default_nettype none

module rbg_power_acc
    import bf_dims_pkg::*;
    import bf_types_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_reset,
    input  wire beam_vec_t i_beam,
    input  wire logic      i_beam_vld,
    input  wire rbg_tag_t  i_tag,
    output rbg_power_t     o_pwr,
    output logic           o_pwr_vld
);

    logic [BEAM_W-1:0] abs_i_nxt [BEAM_NUM];
    logic [BEAM_W-1:0] abs_q_nxt [BEAM_NUM];
    logic [BEAM_W-1:0] abs_i     [BEAM_NUM];
    logic [BEAM_W-1:0] abs_q     [BEAM_NUM];
    pwr_vec_t          mag;
    pwr_vec_t          acc;
    pwr_vec_t          acc_nxt;
    rbg_tag_t          tag_s1;
    rbg_tag_t          tag_s2;

    // --------------------------------------------------
    // stage 1: >>> shift then abs
    // --------------------------------------------------
    always_comb begin : shift_abs
        logic signed [BEAM_W-1:0] sh_i;
        logic signed [BEAM_W-1:0] sh_q;
        for (int b = 0; b < BEAM_NUM; b++) begin
            sh_i = i_beam[b].i;
            sh_q = i_beam[b].q;
            // rounds toward minus infinity
            sh_i = sh_i >>> PWR_SHIFT;
            sh_q = sh_q >>> PWR_SHIFT;
            abs_i_nxt[b] = sh_i[BEAM_W-1] ? -sh_i : sh_i;
            abs_q_nxt[b] = sh_q[BEAM_W-1] ? -sh_q : sh_q;
        end
    end

    always_ff @(posedge i_clk) begin
        for (int b = 0; b < BEAM_NUM; b++) begin
            abs_i[b] <= abs_i_nxt[b];
            abs_q[b] <= abs_q_nxt[b];
        end
    end

    // --------------------------------------------------
    // stage 2: |I| + |Q|
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < BEAM_NUM; b++) begin
            mag[b] <= abs_i[b] + abs_q[b];
        end
    end

    // tag rides along both stages, valid comes from the mac
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            tag_s1 <= '0;
            tag_s2 <= '0;
        end else begin
            tag_s1       <= i_tag;
            tag_s1.valid <= i_beam_vld;
            tag_s2       <= tag_s1;
        end
    end

    // --------------------------------------------------
    // stage 3: rbg accumulation
    // --------------------------------------------------
    always_comb begin
        for (int b = 0; b < BEAM_NUM; b++) begin
            acc_nxt[b] = tag_s2.rbg_first ? mag[b] : acc[b] + mag[b];
        end
    end

    // holds over gaps
    always_ff @(posedge i_clk) begin
        if (tag_s2.valid) begin
            acc <= acc_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (tag_s2.valid && tag_s2.rbg_last) begin
            o_pwr.rbg_idx <= tag_s2.rbg_idx;
            o_pwr.sym_end <= tag_s2.sym_end;
            o_pwr.pwr     <= acc_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pwr_vld <= 1'b0;
        end else begin
            o_pwr_vld <= tag_s2.valid && tag_s2.rbg_last;
        end
    end

endmodule

`default_nettype wire

//--- rbg_tracker.sv
`default_nettype none

module rbg_tracker
    import bf_dims_pkg::*;
    import bf_types_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset,
    input  wire logic       i_re_vld,
    input  wire logic       i_re_sop,
    input  wire logic       i_re_eop,
    input  wire logic [1:0] i_rbg_size,
    output rbg_tag_t        o_tag
);

    logic [RE_CNT_W-1:0]  re_cnt;
    logic [RBG_IDX_W-1:0] rbg_idx;
    logic [RE_CNT_W-1:0]  last_pos;
    logic [RE_CNT_W-1:0]  re_pos;
    logic [RBG_IDX_W-1:0] cur_idx;
    logic                 rbg_full;
    rbg_tag_t             tag_now;
    rbg_tag_t             tag_dly [MAC_LAT];

    // --------------------------------------------------
    // rbg length select, size 3 falls back to 48
    // --------------------------------------------------
    always_comb begin
        case (i_rbg_size)
            2'd1:    last_pos = RE_CNT_W'(RE_PER_RBG_S1 - 1);
            2'd2:    last_pos = RE_CNT_W'(RE_PER_RBG_S2 - 1);
            default: last_pos = RE_CNT_W'(RE_PER_RBG_S0 - 1);
        endcase
    end

    // sop restarts both counts on its own re
    assign re_pos   = i_re_sop ? '0 : re_cnt;
    assign cur_idx  = i_re_sop ? '0 : rbg_idx;
    assign rbg_full = (re_pos == last_pos);

    always_comb begin
        tag_now.valid     = i_re_vld;
        tag_now.rbg_first = i_re_vld && (re_pos == '0);
        tag_now.rbg_last  = i_re_vld && (rbg_full || i_re_eop);
        tag_now.sym_end   = i_re_vld && i_re_eop;
        tag_now.rbg_idx   = cur_idx;
    end

    // --------------------------------------------------
    // counters, only valid res advance
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt  <= '0;
            rbg_idx <= '0;
        end else if (i_re_vld) begin
            if (i_re_eop) begin
                re_cnt  <= '0;
                rbg_idx <= '0;
            end else if (rbg_full) begin
                re_cnt  <= '0;
                rbg_idx <= cur_idx + 1'b1;
            end else begin
                re_cnt  <= re_pos + 1'b1;
                rbg_idx <= cur_idx;
            end
        end
    end

    // align tag with beam output of the mac
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int k = 0; k < MAC_LAT; k++) begin
                tag_dly[k] <= '0;
            end
        end else begin
            tag_dly[0] <= tag_now;
            for (int k = 1; k < MAC_LAT; k++) begin
                tag_dly[k] <= tag_dly[k-1];
            end
        end
    end

    assign o_tag = tag_dly[MAC_LAT-1];

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
bf_dims_pkg.sv
bf_types_pkg.sv
beam_mac.sv
rbg_tracker.sv
rbg_power_acc.sv
pdsch_beam_power.sv
tb_pdsch_beam_power.sv

//--- tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// --------------------------------------------------
// stimulus table
// --------------------------------------------------
typedef enum {WMODE_IDENTITY, WMODE_RANDOM, WMODE_EXTREME} wmode_e;
typedef enum {SMODE_RANDOM, SMODE_EXTREME_NEG} smode_e;

typedef struct {
    string      name;
    logic [1:0] rbg_size;
    int         sym_len;
    int         gap_pct;
    wmode_e     wmode;
    smode_e     smode;
} test_entry_t;

typedef cplx_t cw_mat_t [BEAM_NUM][ANT_NUM];

// running rbg state of the model
typedef struct {
    pwr_vec_t acc;
    int       pos;
    int       idx;
} model_state_t;

function automatic cplx_t model_weight(wmode_e mode, int b, int a);
    cplx_t w;
    w = '0;
    case (mode)
        WMODE_IDENTITY: begin
            if (b == a) begin
                w.i = 16'sd1 <<< 8;
            end
        end
        WMODE_EXTREME:  w = '{i: 16'sh7fff, q: 16'sh8000};
        default:        w = '{i: 16'($urandom), q: 16'($urandom)};
    endcase
    return w;
endfunction

function automatic cplx_t model_sample(smode_e mode);
    cplx_t x;
    if (mode == SMODE_EXTREME_NEG) begin
        x.i = 16'sh8000;
        x.q = 16'sh8000 + 16'($urandom % 8);
    end else begin
        x = '{i: 16'($urandom), q: 16'($urandom)};
    end
    return x;
endfunction

// beam, >>> shift, |I|+|Q| for one re
function automatic pwr_vec_t model_re_power(cw_mat_t cw, ant_vec_t re);
    logic signed [BEAM_W-1:0] acc_re;
    logic signed [BEAM_W-1:0] acc_im;
    pwr_vec_t                 p;
    for (int b = 0; b < BEAM_NUM; b++) begin
        acc_re = '0;
        acc_im = '0;
        for (int a = 0; a < ANT_NUM; a++) begin
            acc_re += cw[b][a].i * re[a].i - cw[b][a].q * re[a].q;
            acc_im += cw[b][a].i * re[a].q + cw[b][a].q * re[a].i;
        end
        acc_re = acc_re >>> PWR_SHIFT;
        acc_im = acc_im >>> PWR_SHIFT;
        p[b] = (acc_re < 0 ? -acc_re : acc_re) + (acc_im < 0 ? -acc_im : acc_im);
    end
    return p;
endfunction

// returns 1 when this re closes an rbg, res then holds the result
function automatic bit model_step(inout model_state_t st, input logic [1:0] size,
                                  input bit sop, input bit eop, input pwr_vec_t p,
                                  output rbg_power_t res);
    int len;
    bit last;
    len = (size == 2'd1) ? RE_PER_RBG_S1 : (size == 2'd2) ? RE_PER_RBG_S2 : RE_PER_RBG_S0;
    if (sop) begin
        st.pos = 0;
        st.idx = 0;
    end
    for (int b = 0; b < BEAM_NUM; b++) begin
        st.acc[b] = (st.pos == 0) ? p[b] : st.acc[b] + p[b];
    end
    last        = (st.pos == len - 1) || eop;
    res.rbg_idx = RBG_IDX_W'(st.idx);
    res.sym_end = eop;
    res.pwr     = st.acc;
    st.pos      = last ? 0 : st.pos + 1;
    st.idx      = eop ? 0 : (last ? st.idx + 1 : st.idx);
    return last;
endfunction

`endif

//--- tb_pdsch_beam_power.sv
`default_nettype none

module tb_pdsch_beam_power
    import bf_dims_pkg::*;
    import bf_types_pkg::*;
;

    `include "tb_model.svh"

    localparam int NUM_TESTS = 8;

    logic       i_clk = 1'b0;
    logic       i_reset;
    ant_vec_t   i_re;
    logic       i_re_vld;
    logic       i_re_sop;
    logic       i_re_eop;
    logic [1:0] i_rbg_size;
    cw_wr_t     i_cw_wr;
    logic       i_cw_wr_en;
    rbg_power_t o_pwr;
    logic       o_pwr_vld;

    test_entry_t tests     [NUM_TESTS];
    int          exp_rbgs  [NUM_TESTS];
    int          got_cnt   [NUM_TESTS];
    int          test_errs [NUM_TESTS];

    cw_mat_t    cur_cw;
    rbg_power_t exp_q [$];
    int         exp_test_q [$];
    int         error_cnt;
    int         check_cnt;
    int         cycle_cnt;
    int         timeout_limit;

    pdsch_beam_power dut_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_re       (i_re),
        .i_re_vld   (i_re_vld),
        .i_re_sop   (i_re_sop),
        .i_re_eop   (i_re_eop),
        .i_rbg_size (i_rbg_size),
        .i_cw_wr    (i_cw_wr),
        .i_cw_wr_en (i_cw_wr_en),
        .o_pwr      (o_pwr),
        .o_pwr_vld  (o_pwr_vld)
    );

    always #4 i_clk = ~i_clk;

    // --------------------------------------------------
    // error reporting and compare tasks
    // --------------------------------------------------
    task automatic report_mismatch(input int t, input string msg);
        $display("FAIL t=%0t %s: %s", $time, tests[t].name, msg);
        error_cnt++;
        test_errs[t]++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        error_cnt++;
    endtask

    task automatic check_tag(input int t, input rbg_power_t got, input rbg_power_t exp);
        check_cnt++;
        if (got.rbg_idx !== exp.rbg_idx || got.sym_end !== exp.sym_end) begin
            report_mismatch(t, $sformatf("rbg_idx %0d sym_end %b, expected %0d %b",
                                         got.rbg_idx, got.sym_end, exp.rbg_idx, exp.sym_end));
        end
    endtask

    task automatic check_power(input int t, input pwr_vec_t got, input pwr_vec_t exp);
        check_cnt++;
        for (int b = 0; b < BEAM_NUM; b++) begin
            if (got[b] !== exp[b]) begin
                report_mismatch(t, $sformatf("beam %0d power %0h, expected %0h",
                                             b, got[b], exp[b]));
            end
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic write_weights(input wmode_e mode);
        cplx_t w;
        for (int b = 0; b < BEAM_NUM; b++) begin
            for (int a = 0; a < ANT_NUM; a++) begin
                @(posedge i_clk);
                w = model_weight(mode, b, a);
                i_re_vld        <= 1'b0;
                i_re_sop        <= 1'b0;
                i_re_eop        <= 1'b0;
                i_cw_wr_en      <= 1'b1;
                i_cw_wr.beam    <= BEAM_IDX_W'(b);
                i_cw_wr.ant     <= ANT_IDX_W'(a);
                i_cw_wr.w       <= w;
                cur_cw[b][a]    = w;
            end
        end
        @(posedge i_clk);
        i_cw_wr_en <= 1'b0;
    endtask

    // one symbol, model results queued as the res go out
    task automatic drive_symbol(input int t);
        test_entry_t  e;
        ant_vec_t     re;
        pwr_vec_t     p;
        rbg_power_t   res;
        model_state_t st;
        int           pos;
        int           pushed;
        bit           sop;
        bit           eop;
        e      = tests[t];
        st.acc = '0;
        st.pos = 0;
        st.idx = 0;
        pos    = 0;
        pushed = 0;
        while (pos < e.sym_len) begin
            @(posedge i_clk);
            i_rbg_size <= e.rbg_size;
            if (($urandom % 100) < e.gap_pct) begin
                // garbage on gap cycles must be ignored
                i_re     <= {$urandom, $urandom, $urandom, $urandom};
                i_re_vld <= 1'b0;
                i_re_sop <= 1'b0;
                i_re_eop <= 1'b0;
            end else begin
                for (int a = 0; a < ANT_NUM; a++) begin
                    re[a] = model_sample(e.smode);
                end
                sop = (pos == 0);
                eop = (pos == e.sym_len - 1);
                i_re     <= re;
                i_re_vld <= 1'b1;
                i_re_sop <= sop;
                i_re_eop <= eop;
                p = model_re_power(cur_cw, re);
                if (model_step(st, e.rbg_size, sop, eop, p, res)) begin
                    exp_q.push_back(res);
                    exp_test_q.push_back(t);
                    pushed++;
                end
                pos++;
            end
        end
        if (pushed != exp_rbgs[t]) begin
            report_error($sformatf("%s: model split the symbol into %0d rbgs, table has %0d",
                                   e.name, pushed, exp_rbgs[t]));
        end
    endtask

    // --------------------------------------------------
    // monitor, sampled away from the driving edge
    // --------------------------------------------------
    always @(negedge i_clk) begin : monitor
        rbg_power_t exp;
        int         t;
        if (i_reset) begin
            if (o_pwr_vld !== 1'b0) begin
                report_error("o_pwr_vld is not low during reset");
            end
        end else if (o_pwr_vld !== 1'b0 && o_pwr_vld !== 1'b1) begin
            report_error("o_pwr_vld is unknown after reset");
        end else if (o_pwr_vld) begin
            if (exp_q.size() == 0) begin
                report_error("o_pwr_vld pulsed while no result was expected");
            end else begin
                exp = exp_q.pop_front();
                t   = exp_test_q.pop_front();
                check_tag(t, o_pwr, exp);
                check_power(t, o_pwr.pwr, exp.pwr);
                got_cnt[t]++;
                if (got_cnt[t] == exp_rbgs[t]) begin
                    $display("test %0d %-14s %0d results, %0d errors",
                             t, tests[t].name, got_cnt[t], test_errs[t]);
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout after %0d cycles, %0d expected results still pending",
                     cycle_cnt, exp_q.size());
            $display("=== FAIL ===");
            $finish;
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        i_reset    = 1'b1;
        i_re       = '0;
        i_re_vld   = 1'b0;
        i_re_sop   = 1'b0;
        i_re_eop   = 1'b0;
        i_rbg_size = 2'd0;
        i_cw_wr    = '0;
        i_cw_wr_en = 1'b0;
        error_cnt  = 0;
        check_cnt  = 0;
        cycle_cnt  = 0;
        void'($urandom(88));

        // name, size, length, gap %, weights, samples
        tests[0] = '{"size0_200",     2'd0, 200,  0, WMODE_RANDOM,   SMODE_RANDOM};
        tests[1] = '{"size1_gaps",    2'd1, 300, 25, WMODE_RANDOM,   SMODE_RANDOM};
        tests[2] = '{"size2_gaps",    2'd2, 400, 25, WMODE_RANDOM,   SMODE_RANDOM};
        tests[3] = '{"identity",      2'd0, 150, 10, WMODE_IDENTITY, SMODE_RANDOM};
        tests[4] = '{"size3_b2b_a",   2'd3, 100,  0, WMODE_IDENTITY, SMODE_RANDOM};
        tests[5] = '{"size3_b2b_b",   2'd3, 120,  0, WMODE_IDENTITY, SMODE_RANDOM};
        tests[6] = '{"weight_change", 2'd1, 100,  0, WMODE_RANDOM,   SMODE_RANDOM};
        tests[7] = '{"extreme_neg",   2'd2, 200,  0, WMODE_EXTREME,  SMODE_EXTREME_NEG};
        exp_rbgs = '{5, 4, 3, 4, 3, 3, 2, 2};

        timeout_limit = 200;
        for (int t = 0; t < NUM_TESTS; t++) begin
            got_cnt[t]    = 0;
            test_errs[t]  = 0;
            timeout_limit += 2 * tests[t].sym_len;
        end

        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            // identity after identity keeps the weights, symbols run back to back
            if (!(t > 0 && tests[t].wmode == WMODE_IDENTITY &&
                  tests[t-1].wmode == WMODE_IDENTITY)) begin
                write_weights(tests[t].wmode);
            end
            drive_symbol(t);
        end
        @(posedge i_clk);
        i_re_vld <= 1'b0;
        i_re_sop <= 1'b0;
        i_re_eop <= 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge i_clk);
        end
        // catch stray pulses after the last result
        repeat (MAC_LAT + PWR_LAT + 5) @(posedge i_clk);

        for (int t = 0; t < NUM_TESTS; t++) begin
            if (got_cnt[t] != exp_rbgs[t]) begin
                report_error($sformatf("%s received %0d results instead of %0d",
                                       tests[t].name, got_cnt[t], exp_rbgs[t]));
            end
        end

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
